// ==== hw/smb_ack_controller.sv ====
`include "smb_consts.svh"

module smb_ack_controller (
    input  logic                 clk,
    input  logic                 rst,
    input  smb_pkg::smb_event_t  ev,
    input  smb_pkg::smb_frame_t  frame,
    input  logic                 tx_bit,
    input  logic                 arb_lost,
    input  logic                 alert_pending,
    input  logic                 frame_ack,
    output smb_pkg::xfer_state_e xfer_state,
    output logic                 sda_drive_low,
    output logic                 busy,
    output logic                 frame_req,
    output smb_pkg::smb_frame_t  frame_out,
    output logic                 alert_clear
);

    logic addr_dev;
    logic addr_ara;
    logic req_open;
    logic write_ack_slot;
    logic reply_state;
    logic target_nack;
    logic master_nack;
    logic cmd_acked;
    logic alert_won;
    logic deliver;

    assign addr_dev = (frame.addr == `SMB_DEV_ADDR);
    assign addr_ara = (frame.addr == `SMB_ARA);
    // a previous frame is still in the four phase handshake
    assign req_open = frame_req | frame_ack;
    assign write_ack_slot = (ev.pos == `SMB_POS_CMD_ACK) || (ev.pos == `SMB_POS_LDB_ACK) ||
                            (ev.pos == `SMB_POS_HDB_ACK);
    assign reply_state = (xfer_state == smb_pkg::XS_READ) || (xfer_state == smb_pkg::XS_ALERT);
    // address slot released by us
    assign target_nack = ev.scl_rise && ev.pos == `SMB_POS_ADDR_ACK &&
                         xfer_state == smb_pkg::XS_IGNORE;
    // master leaves sda high after a reply byte
    assign master_nack = ev.scl_rise && ev.sda && reply_state &&
                         (ev.pos == `SMB_POS_CMD_ACK || ev.pos == `SMB_POS_LDB_ACK);
    // complete write with at least the command acked
    assign deliver = ev.stop && xfer_state == smb_pkg::XS_WRITE && cmd_acked;

    // ****************************************
    // transaction state and data line drive
    // ****************************************
    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            xfer_state    <= smb_pkg::XS_IDLE;
            sda_drive_low <= 1'b0;
            busy          <= 1'b0;
            cmd_acked     <= 1'b0;
            alert_won     <= 1'b0;
        end
        else if (ev.stop || ev.start)
        begin
            // repeated start also begins a fresh address byte
            xfer_state    <= ev.stop ? smb_pkg::XS_IDLE : smb_pkg::XS_ADDR;
            busy          <= ev.start;
            sda_drive_low <= 1'b0;
            cmd_acked     <= 1'b0;
            alert_won     <= 1'b0;
        end
        else if (arb_lost && xfer_state == smb_pkg::XS_ALERT)
        begin
            // lost to another target, stay off the bus until stop
            xfer_state    <= smb_pkg::XS_IGNORE;
            sda_drive_low <= 1'b0;
        end
        else if (ev.scl_fall)
        begin
            sda_drive_low <= 1'b0;
            case (xfer_state)
                smb_pkg::XS_ADDR:
                begin
                    if (ev.pos == `SMB_POS_ADDR_ACK)
                    begin
                        sda_drive_low <= 1'b1;
                        if (addr_dev && !frame.rw && !req_open)
                            xfer_state <= smb_pkg::XS_WRITE;
                        else if (addr_dev && frame.rw)
                            xfer_state <= smb_pkg::XS_READ;
                        else if (addr_ara && frame.rw && alert_pending)
                            xfer_state <= smb_pkg::XS_ALERT;
                        else
                        begin
                            // not ours or back pressure, NACK
                            xfer_state    <= smb_pkg::XS_IGNORE;
                            sda_drive_low <= 1'b0;
                        end
                    end
                end
                smb_pkg::XS_WRITE:
                begin
                    // command and data bytes are always ACKed
                    sda_drive_low <= write_ack_slot;
                    if (ev.pos == `SMB_POS_CMD_ACK)
                        cmd_acked <= 1'b1;
                end
                smb_pkg::XS_READ,
                smb_pkg::XS_ALERT:
                    sda_drive_low <= ~tx_bit;
                default:
                    sda_drive_low <= 1'b0;
            endcase
        end
        else if (ev.scl_rise)
        begin
            // alert byte went out whole
            if (ev.pos == `SMB_POS_CMD_ACK && xfer_state == smb_pkg::XS_ALERT && !arb_lost)
                alert_won <= 1'b1;
            if (target_nack || master_nack)
            begin
                xfer_state <= smb_pkg::XS_IGNORE;
                busy       <= 1'b0;
            end
        end
    end

    // ****************************************
    // host handshake and alert clear
    // ****************************************
    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            frame_req   <= 1'b0;
            alert_clear <= 1'b0;
        end
        else
        begin
            alert_clear <= ev.stop &&
                           (alert_won || (deliver && frame.cmd == smb_pkg::CMD_CLEAR_FAULTS));
            // host ack drops the request, host then releases ack
            if (frame_req && frame_ack)
                frame_req <= 1'b0;
            else if (deliver)
                frame_req <= 1'b1;
        end
    end

    // frame held for the host while the request is open
    always_ff @(posedge clk)
    begin
        if (deliver)
            frame_out <= frame;
    end

endmodule

// ==== hw/smb_consts.svh ====
`ifndef SMB_CONSTS_SVH
`define SMB_CONSTS_SVH

// our own 7 bit target address
`define SMB_DEV_ADDR        7'd92

// smbalert alert response address
`define SMB_ARA             7'b0001100

// depth of the bus line synchronizers
`define SMB_SYNC_STAGES     2

// bit position counter width and ceiling
`define SMB_POS_W           6
`define SMB_POS_MAX         6'd38

// acknowledge slots of address, command, low and high data byte
`define SMB_POS_ADDR_ACK    6'd9
`define SMB_POS_CMD_ACK     6'd18
`define SMB_POS_LDB_ACK     6'd27
`define SMB_POS_HDB_ACK     6'd36

// first bit of each byte after the address
`define SMB_POS_CMD_FIRST   6'd10
`define SMB_POS_LDB_FIRST   6'd19
`define SMB_POS_HDB_FIRST   6'd28

`endif

// ==== hw/smb_frame_receiver.sv ====
`include "smb_consts.svh"

module smb_frame_receiver (
    input  logic                clk,
    input  logic                rst,
    input  smb_pkg::smb_event_t ev,
    output smb_pkg::smb_frame_t frame
);

    logic in_addr;
    logic in_cmd;
    logic in_ldb;
    logic in_hdb;
    logic byte_done;

    // bit windows, positions 1 to 8 hold address and rw
    assign in_addr = (ev.pos != '0) && (ev.pos < `SMB_POS_ADDR_ACK);
    assign in_cmd  = (ev.pos >= `SMB_POS_CMD_FIRST) && (ev.pos < `SMB_POS_CMD_ACK);
    assign in_ldb  = (ev.pos >= `SMB_POS_LDB_FIRST) && (ev.pos < `SMB_POS_LDB_ACK);
    assign in_hdb  = (ev.pos >= `SMB_POS_HDB_FIRST) && (ev.pos < `SMB_POS_HDB_ACK);

    // last bit of a data byte
    assign byte_done = (ev.pos == `SMB_POS_LDB_ACK - 6'd1) ||
                       (ev.pos == `SMB_POS_HDB_ACK - 6'd1);

    // ****************************************
    // shift bits in on scl rising
    // ****************************************
    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
            frame <= '0;
        else if (ev.start)
            // every transaction starts from a clean frame
            frame <= '0;
        else if (ev.scl_rise)
        begin
            if (in_addr)
                {frame.addr, frame.rw} <= {frame.addr[5:0], frame.rw, ev.sda};
            else if (!frame.rw)
            begin
                // write direction only, msb first
                if (in_cmd)
                    frame.cmd <= {frame.cmd[6:0], ev.sda};
                if (in_ldb)
                    frame.ldb <= {frame.ldb[6:0], ev.sda};
                if (in_hdb)
                    frame.hdb <= {frame.hdb[6:0], ev.sda};
                if (byte_done)
                    frame.count <= frame.count + 2'd1;
            end
        end
    end

endmodule

// ==== hw/smb_line_monitor.sv ====
`include "smb_consts.svh"

module smb_line_monitor (
    input  logic                clk,
    input  logic                rst,
    input  logic                scl,
    input  logic                sda_in,
    input  logic                busy,
    output smb_pkg::smb_event_t ev
);

    // synchronizer chains, newest bit at index 0
    logic [`SMB_SYNC_STAGES-1:0] scl_sync;
    logic [`SMB_SYNC_STAGES-1:0] sda_sync;
    logic                        scl_s;
    logic                        sda_s;
    // one cycle older copy of the synchronized levels
    logic                        scl_prev;
    logic                        sda_prev;
    logic                        scl_rise_c;
    logic                        scl_fall_c;
    logic                        start_c;
    logic                        stop_c;

    assign scl_s = scl_sync[`SMB_SYNC_STAGES-1];
    assign sda_s = sda_sync[`SMB_SYNC_STAGES-1];

    assign scl_rise_c = scl_s & ~scl_prev;
    assign scl_fall_c = ~scl_s & scl_prev;
    // start is sda falling with scl held high
    assign start_c = scl_s & scl_prev & sda_prev & ~sda_s;
    // stop is sda rising with scl held high
    assign stop_c = scl_s & scl_prev & ~sda_prev & sda_s;

    // ****************************************
    // synchronizers, idle bus reads high
    // ****************************************
    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            scl_sync <= '1;
            sda_sync <= '1;
        end
        else
        begin
            scl_sync <= {scl_sync[`SMB_SYNC_STAGES-2:0], scl};
            sda_sync <= {sda_sync[`SMB_SYNC_STAGES-2:0], sda_in};
        end
    end

    // ****************************************
    // edge register, event flags and bit position
    // ****************************************
    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            scl_prev    <= 1'b1;
            sda_prev    <= 1'b1;
            ev.start    <= 1'b0;
            ev.stop     <= 1'b0;
            ev.scl_rise <= 1'b0;
            ev.scl_fall <= 1'b0;
            ev.sda      <= 1'b1;
            ev.pos      <= '0;
        end
        else
        begin
            scl_prev    <= scl_s;
            sda_prev    <= sda_s;
            ev.start    <= start_c;
            ev.stop     <= stop_c;
            ev.scl_rise <= scl_rise_c;
            ev.scl_fall <= scl_fall_c;
            ev.sda      <= sda_s;
            // position moves together with its scl_fall flag
            if (start_c || stop_c)
                ev.pos <= '0;
            else if (scl_fall_c && busy && ev.pos < `SMB_POS_MAX)
                ev.pos <= ev.pos + 1'b1;
        end
    end

endmodule

// ==== hw/smb_pkg.sv ====
`include "smb_consts.svh"

package smb_pkg;

    // ****************************************
    // bus events seen by every block
    // ****************************************
    typedef struct packed {
        // one cycle pulses
        logic                  start;
        logic                  stop;
        logic                  scl_rise;
        logic                  scl_fall;
        // synchronized data line level
        logic                  sda;
        // scl falls since start
        logic [`SMB_POS_W-1:0] pos;
    } smb_event_t;

    // ****************************************
    // received write frame
    // ****************************************
    typedef struct packed {
        logic [6:0] addr;
        logic       rw;
        logic [7:0] cmd;
        logic [7:0] ldb;
        logic [7:0] hdb;
        // data bytes received after the command
        logic [1:0] count;
    } smb_frame_t;

    // transaction state after the address byte
    typedef enum logic [2:0] {
        XS_IDLE,
        XS_ADDR,
        XS_WRITE,
        XS_READ,
        XS_ALERT,
        XS_IGNORE
    } xfer_state_e;

    // pmbus command codes handled here
    typedef enum logic [7:0] {
        CMD_CLEAR_FAULTS = 8'h03
    } smb_cmd_e;

endpackage

// ==== hw/smb_reply_transmitter.sv ====
`include "smb_consts.svh"

module smb_reply_transmitter (
    input  logic                 clk,
    input  logic                 rst,
    input  smb_pkg::smb_event_t  ev,
    input  smb_pkg::xfer_state_e xfer_state,
    input  logic [7:0]           rd_ldb,
    input  logic [7:0]           rd_hdb,
    output logic                 tx_bit,
    output logic                 arb_lost
);

    // byte being sent, msb goes out first
    logic [7:0] shreg;
    logic       in_first;
    logic       in_second;

    // bit windows of the two reply bytes
    assign in_first  = (ev.pos >= `SMB_POS_CMD_FIRST) && (ev.pos < `SMB_POS_CMD_ACK);
    assign in_second = (ev.pos >= `SMB_POS_LDB_FIRST) && (ev.pos < `SMB_POS_LDB_ACK);

    // release the line outside the data bits
    assign tx_bit = (in_first || in_second) ? shreg[7] : 1'b1;

    // ****************************************
    // load and shift on scl rising
    // ****************************************
    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
            shreg <= '1;
        else if (ev.scl_rise)
        begin
            if (ev.pos == `SMB_POS_ADDR_ACK)
            begin
                // alert response sends our address with a zero lsb
                if (xfer_state == smb_pkg::XS_ALERT)
                    shreg <= {`SMB_DEV_ADDR, 1'b0};
                else
                    shreg <= rd_ldb;
            end
            else if (ev.pos == `SMB_POS_CMD_ACK)
                shreg <= rd_hdb;
            else if (in_first || in_second)
                // bit just sampled by the master, move to the next one
                shreg <= {shreg[6:0], 1'b1};
        end
    end

    // ****************************************
    // arbitration of the alert response
    // ****************************************
    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
            arb_lost <= 1'b0;
        else if (ev.start)
            arb_lost <= 1'b0;
        else if (ev.scl_rise && xfer_state == smb_pkg::XS_ALERT && in_first)
        begin
            // we released but another target holds the line low
            if (tx_bit && !ev.sda)
                arb_lost <= 1'b1;
        end
    end

endmodule

// ==== hw/smb_target.sv ====
module smb_target (
    input  logic                clk,
    input  logic                rst,
    // wired bus levels
    input  logic                scl,
    input  logic                sda_in,
    output logic                sda_drive_low,
    // host write handshake
    output logic                frame_req,
    output smb_pkg::smb_frame_t frame,
    input  logic                frame_ack,
    // host read data
    input  logic [7:0]          rd_ldb,
    input  logic [7:0]          rd_hdb,
    // smbalert
    input  logic                alert_pending,
    output logic                alert_clear,
    output logic                busy
);

    smb_pkg::smb_event_t  ev;
    smb_pkg::smb_frame_t  rx_frame;
    smb_pkg::xfer_state_e xfer_state;
    logic                 tx_bit;
    logic                 arb_lost;

    // ****************************************
    // line watcher feeds all other blocks
    // ****************************************
    smb_line_monitor u_line_monitor (
        .clk    (clk),
        .rst    (rst),
        .scl    (scl),
        .sda_in (sda_in),
        .busy   (busy),
        .ev     (ev)
    );

    // receive and transmit side by side
    smb_frame_receiver u_frame_receiver (
        .clk   (clk),
        .rst   (rst),
        .ev    (ev),
        .frame (rx_frame)
    );

    smb_reply_transmitter u_reply_transmitter (
        .clk        (clk),
        .rst        (rst),
        .ev         (ev),
        .xfer_state (xfer_state),
        .rd_ldb     (rd_ldb),
        .rd_hdb     (rd_hdb),
        .tx_bit     (tx_bit),
        .arb_lost   (arb_lost)
    );

    // merges both into the data line drive
    smb_ack_controller u_ack_controller (
        .clk           (clk),
        .rst           (rst),
        .ev            (ev),
        .frame         (rx_frame),
        .tx_bit        (tx_bit),
        .arb_lost      (arb_lost),
        .alert_pending (alert_pending),
        .frame_ack     (frame_ack),
        .xfer_state    (xfer_state),
        .sda_drive_low (sda_drive_low),
        .busy          (busy),
        .frame_req     (frame_req),
        .frame_out     (frame),
        .alert_clear   (alert_clear)
    );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the smb target testbench with verilator

# work from the project root
cd "$(dirname "$0")" || exit 1
LOG=sim.log

# compile rtl, bound properties and testbench
verilator --binary --timing --assert -Wno-fatal -f src.f \
    --top-module tb_smb_target -Mdir obj_dir -o tb_smb_target
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

# run, keep the transcript
./obj_dir/tb_smb_target > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# the testbench verdict decides
if grep -q "ERRORS FOUND" "$LOG"; then
    exit 1
fi
exit 0

// ==== src.f ====
+incdir+hw
hw/smb_pkg.sv
hw/smb_line_monitor.sv
hw/smb_frame_receiver.sv
hw/smb_reply_transmitter.sv
hw/smb_ack_controller.sv
hw/smb_target.sv
verification/smb_target_props.sv
verification/tb_smb_target.sv

// ==== verification/smb_target_props.sv ====
module smb_target_props (
    input logic                clk,
    input logic                rst,
    input logic                sda_drive_low,
    input logic                busy,
    input logic                frame_req,
    input logic                frame_ack,
    input smb_pkg::smb_frame_t frame,
    input logic                alert_clear
);

    // ****************************************
    // alert clear and host handshake
    // ****************************************
    // single cycle pulse
    alert_clear_pulse: assert property (@(posedge clk) disable iff (!rst)
        alert_clear |=> !alert_clear)
        else $error("alert_clear high for more than one cycle");

    // request waits for the host
    req_held: assert property (@(posedge clk) disable iff (!rst)
        frame_req && !frame_ack |=> frame_req)
        else $error("frame_req dropped before frame_ack");

    // frame frozen while offered to the host
    frame_held: assert property (@(posedge clk) disable iff (!rst)
        frame_req && !frame_ack |=> $stable(frame))
        else $error("frame changed while frame_req was open");

    // ****************************************
    // bus drive and reset values
    // ****************************************
    // target stays off the bus when idle
    drive_only_busy: assert property (@(posedge clk) disable iff (!rst)
        !busy |-> !sda_drive_low)
        else $error("sda_drive_low set outside a transaction");

    reset_values: assert property (@(posedge clk)
        $rose(rst) |-> !sda_drive_low && !frame_req && !alert_clear && !busy)
        else $error("outputs active after reset");

endmodule

bind smb_target smb_target_props u_props (
    .clk           (clk),
    .rst           (rst),
    .sda_drive_low (sda_drive_low),
    .busy          (busy),
    .frame_req     (frame_req),
    .frame_ack     (frame_ack),
    .frame         (frame),
    .alert_clear   (alert_clear)
);

// ==== verification/tb_smb_target.sv ====
`include "smb_consts.svh"

module tb_smb_target;

    logic                clk;
    logic                rst;
    logic                scl;
    logic                sda_m;
    logic                sda_bus;
    logic                frame_ack;
    logic [7:0]          rd_ldb;
    logic [7:0]          rd_hdb;
    logic                alert_pending;
    logic                sda_drive_low;
    logic                frame_req;
    logic                alert_clear;
    logic                busy;
    smb_pkg::smb_frame_t frame;

    logic [31:0]         lcg_state;
    int                  error_count;
    int                  check_count;
    int                  test_errors;
    int                  clear_pulses = 0;

    // open drain bus, low wins
    assign sda_bus = sda_m & ~sda_drive_low;

    smb_target DUT (
        .clk           (clk),
        .rst           (rst),
        .scl           (scl),
        .sda_in        (sda_bus),
        .sda_drive_low (sda_drive_low),
        .frame_req     (frame_req),
        .frame         (frame),
        .frame_ack     (frame_ack),
        .rd_ldb        (rd_ldb),
        .rd_hdb        (rd_hdb),
        .alert_pending (alert_pending),
        .alert_clear   (alert_clear),
        .busy          (busy)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // alert_clear pulses, sampled between edges
    always @(negedge clk)
    begin
        if (alert_clear)
            clear_pulses++;
    end

    // ****************************************
    // helpers
    // ****************************************
    // lcg, upper bits are the better ones
    function automatic logic [7:0] rand_byte();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31:24];
    endfunction

    task automatic tick(input int n);
        repeat (n) @(posedge clk);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        assert (got === exp)
        else
        begin
            $display("FAILED %s got %h expected %h", name, got, exp);
            error_count++;
        end
    endtask

    // poll frame_req (sel 0) or busy (sel 1), bounded
    task automatic wait_output(input int sel, input logic value, input string what);
        int   n;
        logic cur;
        n = 0;
        cur = ~value;
        while (cur !== value && n < 4000)
        begin
            @(negedge clk);
            cur = (sel == 0) ? frame_req : busy;
            n++;
        end
        if (cur !== value)
        begin
            $display("timeout while waiting for %s", what);
            error_count++;
        end
        @(posedge clk);
    endtask

    task automatic end_test(input string name);
        if (error_count == test_errors)
            $display("%s: ok", name);
        else
            $display("%s: %0d check(s) failed", name, error_count - test_errors);
        test_errors = error_count;
    endtask

    // ****************************************
    // bus master, 16 clk per half bit
    // ****************************************
    // sda moves mid low phase, bus read back mid high phase
    task automatic clock_bit(input logic b, output logic seen);
        tick(8);
        sda_m <= b;
        tick(8);
        scl <= 1'b1;
        tick(8);
        @(negedge clk);
        seen = sda_bus;
        tick(8);
        scl <= 1'b0;
    endtask

    task automatic send_start();
        tick(16);
        sda_m <= 1'b0;
        tick(16);
        scl <= 1'b0;
    endtask

    task automatic send_stop();
        tick(8);
        sda_m <= 1'b0;
        tick(8);
        scl <= 1'b1;
        tick(16);
        sda_m <= 1'b1;
        tick(16);
    endtask

    task automatic write_byte(input logic [7:0] b, output logic acked);
        logic seen;
        int   i;
        for (i = 7; i >= 0; i--)
            clock_bit(b[i], seen);
        // release for the target's ack
        clock_bit(1'b1, seen);
        acked = ~seen;
    endtask

    task automatic read_byte(input logic ack, output logic [7:0] b);
        logic seen;
        int   i;
        for (i = 7; i >= 0; i--)
        begin
            clock_bit(1'b1, seen);
            b[i] = seen;
        end
        clock_bit(~ack, seen);
    endtask

    // acks is {hdb, ldb, cmd, addr}, stops early on address NACK
    task automatic write_frame(input logic [6:0] addr, input logic [7:0] cmd, input int n,
                               input logic [7:0] ldb, input logic [7:0] hdb,
                               output logic [3:0] acks);
        logic a;
        acks = '0;
        send_start();
        write_byte({addr, 1'b0}, a);
        acks[0] = a;
        if (a)
        begin
            write_byte(cmd, a);
            acks[1] = a;
            if (n > 0)
            begin
                write_byte(ldb, a);
                acks[2] = a;
            end
            if (n > 1)
            begin
                write_byte(hdb, a);
                acks[3] = a;
            end
        end
        send_stop();
    endtask

    task automatic check_frame(input logic [7:0] cmd, input logic [7:0] ldb,
                               input logic [7:0] hdb, input logic [1:0] count);
        check_value("frame.addr", frame.addr, `SMB_DEV_ADDR);
        check_value("frame.rw", frame.rw, 1'b0);
        check_value("frame.cmd", frame.cmd, cmd);
        check_value("frame.ldb", frame.ldb, ldb);
        check_value("frame.hdb", frame.hdb, hdb);
        check_value("frame.count", frame.count, count);
    endtask

    // host side of the four phase handshake
    task automatic finish_handshake();
        frame_ack <= 1'b1;
        wait_output(0, 1'b0, "frame_req to fall");
        frame_ack <= 1'b0;
        tick(2);
    endtask

    // ****************************************
    // tests
    // ****************************************
    initial
    begin
        logic [3:0] acks;
        logic       acked;
        logic       seen;
        logic       released;
        logic       req_seen;
        logic [7:0] cmd;
        logic [7:0] ldb;
        logic [7:0] hdb;
        logic [7:0] got;
        int         pulses;
        int         i;
        rst = 1'b0;
        scl = 1'b1;
        sda_m = 1'b1;
        frame_ack = 1'b0;
        rd_ldb = 8'h00;
        rd_hdb = 8'h00;
        alert_pending = 1'b0;
        lcg_state = 32'd53;
        error_count = 0;
        check_count = 0;
        test_errors = 0;
        tick(10);
        rst <= 1'b1;
        tick(20);

        // command and two data bytes
        cmd = rand_byte();
        ldb = rand_byte();
        hdb = rand_byte();
        write_frame(`SMB_DEV_ADDR, cmd, 2, ldb, hdb, acks);
        check_value("ack slots", acks, 4'hf);
        wait_output(0, 1'b1, "frame_req to rise");
        check_frame(cmd, ldb, hdb, 2'd2);
        finish_handshake();
        end_test("test 1 write with two data bytes");

        // foreign address, no ack and no frame
        send_start();
        write_byte({7'h21, 1'b0}, acked);
        check_value("sda at address ack slot", acked, 1'b0);
        wait_output(1, 1'b0, "busy to fall after NACK");
        send_stop();
        req_seen = 1'b0;
        repeat (64)
        begin
            @(negedge clk);
            req_seen |= frame_req;
        end
        check_value("frame_req", req_seen, 1'b0);
        end_test("test 2 write to another address");

        // two byte read, msb first, master NACKs the last byte
        ldb = rand_byte();
        hdb = rand_byte();
        @(posedge clk);
        rd_ldb <= ldb;
        rd_hdb <= hdb;
        send_start();
        write_byte({`SMB_DEV_ADDR, 1'b1}, acked);
        check_value("read address ack", acked, 1'b1);
        read_byte(1'b1, got);
        check_value("rd_ldb on bus", got, ldb);
        read_byte(1'b0, got);
        check_value("rd_hdb on bus", got, hdb);
        @(negedge clk);
        check_value("sda_drive_low", sda_drive_low, 1'b0);
        wait_output(1, 1'b0, "busy to fall after master NACK");
        send_stop();
        end_test("test 3 read of two bytes");

        // alert response won, then lost
        alert_pending <= 1'b1;
        pulses = clear_pulses;
        send_start();
        write_byte({`SMB_ARA, 1'b1}, acked);
        check_value("ara ack", acked, 1'b1);
        read_byte(1'b0, got);
        check_value("alert response byte", got, 8'hb8);
        send_stop();
        tick(4);
        check_value("alert_clear pulses", clear_pulses - pulses, 1);
        pulses = clear_pulses;
        send_start();
        write_byte({`SMB_ARA, 1'b1}, acked);
        // target sends 1 first, master pulls it low
        clock_bit(1'b0, seen);
        released = 1'b1;
        for (i = 0; i < 7; i++)
        begin
            clock_bit(1'b1, seen);
            released &= seen;
        end
        clock_bit(1'b1, seen);
        check_value("sda released after lost bit", released, 1'b1);
        send_stop();
        tick(4);
        check_value("alert_clear pulses", clear_pulses - pulses, 0);
        alert_pending <= 1'b0;
        end_test("test 4 alert response");

        // CLEAR_FAULTS write
        pulses = clear_pulses;
        write_frame(`SMB_DEV_ADDR, 8'h03, 0, 8'h00, 8'h00, acks);
        check_value("ack slots", acks, 4'h3);
        wait_output(0, 1'b1, "frame_req to rise");
        check_frame(8'h03, 8'h00, 8'h00, 2'd0);
        check_value("alert_clear pulses", clear_pulses - pulses, 1);
        finish_handshake();
        end_test("test 5 clear faults");

        // back pressure while a request is open
        cmd = rand_byte();
        ldb = rand_byte();
        hdb = rand_byte();
        write_frame(`SMB_DEV_ADDR, cmd, 2, ldb, hdb, acks);
        wait_output(0, 1'b1, "frame_req to rise");
        write_frame(`SMB_DEV_ADDR, ldb, 2, hdb, cmd, acks);
        check_value("ack slots with open request", acks, 4'h0);
        check_frame(cmd, ldb, hdb, 2'd2);
        finish_handshake();
        write_frame(`SMB_DEV_ADDR, ldb, 2, hdb, cmd, acks);
        check_value("ack slots after handshake", acks, 4'hf);
        wait_output(0, 1'b1, "frame_req to rise");
        check_frame(ldb, hdb, cmd, 2'd2);
        finish_handshake();
        end_test("test 6 back pressure");

        $display("checks: %0d, failed: %0d", check_count, error_count);
        if (error_count == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule
